// File: design/sme_settings.svh
`ifndef SME_SETTINGS_SVH
`define SME_SETTINGS_SVH

// Character and buffer sizing
`define SME_CHAR_W     8
`define SME_STR_MAX    32
`define SME_PAT_MAX    8

// Index widths cover one past the last slot
`define SME_STR_IDX_W  6
`define SME_PAT_IDX_W  4

// Pattern metacharacters
`define SME_CH_HAT     8'h5E
`define SME_CH_DOLLAR  8'h24
`define SME_CH_DOT     8'h2E

// Word separator used by both anchors
`define SME_CH_SPACE   8'h20

`endif

// File: design/sme_pkg.sv
`default_nettype none

package sme_pkg;

    `include "sme_settings.svh"

    typedef logic [`SME_CHAR_W-1:0]    char_t;
    typedef logic [`SME_STR_IDX_W-1:0] str_idx_t;
    typedef logic [`SME_PAT_IDX_W-1:0] pat_idx_t;

    // Decoded pattern element
    typedef enum logic [1:0]
    {
        ELEM_LITERAL,
        ELEM_ANY,
        ELEM_LINE_START,
        ELEM_LINE_END
    } elem_kind_e;

    typedef enum logic [1:0]
    {
        ST_LOAD,
        ST_SEARCH,
        ST_DONE
    } search_state_e;

    // String as seen at the current string pointer
    typedef struct packed
    {
        char_t cur_char;
        char_t prev_char;
        logic  at_start;
        logic  at_end;
    } str_view_t;

    typedef struct packed
    {
        logic hit;
        logic consume;
    } elem_result_t;

endpackage

`default_nettype wire

// File: design/sme_char_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "sme_settings.svh"

module sme_char_store
(
    input  logic                   clk,
    input  logic                   reset,
    input  sme_pkg::char_t         chardata,
    input  logic                   isstring,
    input  logic                   ispattern,
    input  sme_pkg::search_state_e state,
    input  sme_pkg::str_idx_t      str_ptr,
    input  sme_pkg::pat_idx_t      pat_ptr,
    output sme_pkg::char_t         cur_char,
    output sme_pkg::char_t         prev_char,
    output sme_pkg::char_t         pat_char,
    output sme_pkg::str_idx_t      str_len,
    output sme_pkg::pat_idx_t      pat_len,
    output logic                   job_start
);
    import sme_pkg::*;

    localparam int       STR_AW  = $clog2(`SME_STR_MAX);
    localparam int       PAT_AW  = $clog2(`SME_PAT_MAX);
    localparam str_idx_t STR_CAP = str_idx_t'(`SME_STR_MAX);
    localparam pat_idx_t PAT_CAP = pat_idx_t'(`SME_PAT_MAX);

    char_t    str_mem [`SME_STR_MAX];
    char_t    pat_mem [`SME_PAT_MAX];
    logic     str_wr;
    logic     pat_wr;
    logic     prev_str;
    logic     prev_pat;
    logic     str_room;
    logic     pat_room;
    str_idx_t str_wr_idx;
    pat_idx_t pat_wr_idx;
    str_idx_t prev_ptr;

    // =========================================================================
    // Write side
    // =========================================================================
    assign str_wr = (state == ST_LOAD) && isstring;
    assign pat_wr = (state == ST_LOAD) && ispattern;

    // First byte of a run goes to slot zero
    assign str_wr_idx = prev_str ? str_len : '0;
    assign pat_wr_idx = prev_pat ? pat_len : '0;
    assign str_room   = str_wr_idx < STR_CAP;
    assign pat_room   = pat_wr_idx < PAT_CAP;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            prev_str <= 1'b0;
            prev_pat <= 1'b0;
            str_len  <= '0;
            pat_len  <= '0;
        end
        else
        begin
            prev_str <= str_wr;
            prev_pat <= pat_wr;
            if (str_wr && str_room)
                str_len <= str_wr_idx + 1'b1;
            if (pat_wr && pat_room)
                pat_len <= pat_wr_idx + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (str_wr && str_room)
            str_mem[str_wr_idx[STR_AW-1:0]] <= chardata;
        if (pat_wr && pat_room)
            pat_mem[pat_wr_idx[PAT_AW-1:0]] <= chardata;
    end

    // Pattern run just ended and the bus is idle
    assign job_start = (state == ST_LOAD) && prev_pat && !isstring && !ispattern;

    // =========================================================================
    // Read side
    // =========================================================================
    assign prev_ptr = str_ptr - 1'b1;

    // Zero outside the stored text
    assign cur_char  = (str_ptr < str_len) ? str_mem[str_ptr[STR_AW-1:0]] : '0;
    assign prev_char = ((str_ptr != '0) && (str_ptr <= str_len)) ?
                       str_mem[prev_ptr[STR_AW-1:0]] : '0;
    assign pat_char  = (pat_ptr < pat_len) ? pat_mem[pat_ptr[PAT_AW-1:0]] : '0;

endmodule

`default_nettype wire

// File: design/sme_elem_compare.sv
`timescale 1ns/10ps
`default_nettype none

`include "sme_settings.svh"

module sme_elem_compare
(
    input  sme_pkg::str_view_t    view,
    input  sme_pkg::char_t        pat_char,
    output sme_pkg::elem_result_t result
);
    import sme_pkg::*;

    elem_kind_e kind;
    logic       cur_space;
    logic       prev_space;

    // Opcode decode
    always_comb
    begin
        case (pat_char)
            `SME_CH_DOT:    kind = ELEM_ANY;
            `SME_CH_HAT:    kind = ELEM_LINE_START;
            `SME_CH_DOLLAR: kind = ELEM_LINE_END;
            default:        kind = ELEM_LITERAL;
        endcase
    end

    assign cur_space  = view.cur_char == `SME_CH_SPACE;
    assign prev_space = view.prev_char == `SME_CH_SPACE;

    always_comb
    begin
        result.hit     = 1'b0;
        result.consume = 1'b0;
        case (kind)
            ELEM_LITERAL:
            begin
                result.hit     = !view.at_end && (view.cur_char == pat_char);
                result.consume = 1'b1;
            end
            ELEM_ANY:
            begin
                result.hit     = !view.at_end;
                result.consume = 1'b1;
            end
            // Anchors are zero width
            ELEM_LINE_START:
            begin
                result.hit = view.at_start || prev_space;
            end
            ELEM_LINE_END:
            begin
                result.hit = view.at_end || cur_space;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/sme_search_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module sme_search_ctrl
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   job_start,
    input  sme_pkg::char_t         cur_char,
    input  sme_pkg::char_t         prev_char,
    input  sme_pkg::char_t         pat_char,
    input  sme_pkg::str_idx_t      str_len,
    input  sme_pkg::pat_idx_t      pat_len,
    input  sme_pkg::elem_result_t  elem,
    output sme_pkg::str_view_t     view,
    output sme_pkg::search_state_e state,
    output sme_pkg::str_idx_t      str_ptr,
    output sme_pkg::pat_idx_t      pat_ptr,
    output logic                   valid,
    output logic                   match,
    output sme_pkg::str_idx_t      match_index
);
    import sme_pkg::*;

    str_idx_t frame_ptr;
    logic     last_elem;
    logic     found;
    logic     last_frame;

    // =========================================================================
    // String view at the string pointer
    // =========================================================================
    always_comb
    begin
        view.cur_char  = cur_char;
        view.prev_char = prev_char;
        view.at_start  = str_ptr == '0;
        view.at_end    = str_ptr == str_len;
    end

    // =========================================================================
    // Search decisions
    // =========================================================================
    assign last_elem  = pat_ptr == (pat_len - 1'b1);

    assign found      = elem.hit && last_elem;
    assign last_frame = frame_ptr == str_len;

    // =========================================================================
    // Job FSM and pointers
    // =========================================================================
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state       <= ST_LOAD;
            frame_ptr   <= '0;
            str_ptr     <= '0;
            pat_ptr     <= '0;
            match       <= 1'b0;
            match_index <= '0;
        end
        else
        begin
            case (state)
                ST_LOAD:
                begin
                    if (job_start)
                    begin
                        state     <= ST_SEARCH;
                        frame_ptr <= '0;
                        str_ptr   <= '0;
                        pat_ptr   <= '0;
                    end
                end
                ST_SEARCH:
                begin
                    if (found)
                    begin
                        state       <= ST_DONE;
                        match       <= 1'b1;
                        match_index <= frame_ptr;
                    end
                    else if (elem.hit)
                    begin
                        pat_ptr <= pat_ptr + 1'b1;
                        str_ptr <= str_ptr + str_idx_t'(elem.consume);
                    end
                    else if (last_frame)
                    begin
                        // Every start position tried
                        state <= ST_DONE;
                        match <= 1'b0;
                    end
                    else
                    begin
                        // Retry from the next start position
                        frame_ptr <= frame_ptr + 1'b1;
                        str_ptr   <= frame_ptr + 1'b1;
                        pat_ptr   <= '0;
                    end
                end
                ST_DONE:
                begin
                    state <= ST_LOAD;
                    match <= 1'b0;
                end
                default:
                begin
                    state <= ST_LOAD;
                end
            endcase
        end
    end

    // Result is presented for the single DONE cycle
    assign valid = state == ST_DONE;

endmodule

`default_nettype wire

// File: design/sme_top.sv
`timescale 1ns/10ps
`default_nettype none

module sme_top
(
    input  logic              clk,
    input  logic              reset,
    input  sme_pkg::char_t    chardata,
    input  logic              isstring,
    input  logic              ispattern,
    output logic              valid,
    output logic              match,
    output sme_pkg::str_idx_t match_index
);
    import sme_pkg::*;

    search_state_e state;
    str_idx_t      str_ptr;
    str_idx_t      str_len;
    pat_idx_t      pat_ptr;
    pat_idx_t      pat_len;
    char_t         cur_char;
    char_t         prev_char;
    char_t         pat_char;
    logic          job_start;
    str_view_t     view;
    elem_result_t  elem;

    // String and pattern buffers
    sme_char_store u_store
    (
        .clk       (clk),
        .reset     (reset),
        .chardata  (chardata),
        .isstring  (isstring),
        .ispattern (ispattern),
        .state     (state),
        .str_ptr   (str_ptr),
        .pat_ptr   (pat_ptr),
        .cur_char  (cur_char),
        .prev_char (prev_char),
        .pat_char  (pat_char),
        .str_len   (str_len),
        .pat_len   (pat_len),
        .job_start (job_start)
    );

    sme_search_ctrl u_ctrl
    (
        .clk         (clk),
        .reset       (reset),
        .job_start   (job_start),
        .cur_char    (cur_char),
        .prev_char   (prev_char),
        .pat_char    (pat_char),
        .str_len     (str_len),
        .pat_len     (pat_len),
        .elem        (elem),
        .view        (view),
        .state       (state),
        .str_ptr     (str_ptr),
        .pat_ptr     (pat_ptr),
        .valid       (valid),
        .match       (match),
        .match_index (match_index)
    );

    // One element evaluated per search cycle
    sme_elem_compare u_cmp
    (
        .view     (view),
        .pat_char (pat_char),
        .result   (elem)
    );

endmodule

`default_nettype wire

// File: tests/sme_props.sv
`timescale 1ns/10ps
`default_nettype none

module sme_props
(
    input logic clk,
    input logic reset,
    input logic isstring,
    input logic ispattern,
    input logic job_start,
    input logic valid,
    input logic match
);
    logic in_job;

    // Open from job start until the result is presented
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            in_job <= 1'b0;
        else if (job_start)
            in_job <= 1'b1;
        else if (valid)
            in_job <= 1'b0;
    end

    valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
        valid |=> !valid)
        else $error("valid held for more than one cycle");

    match_needs_valid: assert property (@(posedge clk) disable iff (reset)
        match |-> valid)
        else $error("match high without valid");

    strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(isstring && ispattern))
        else $error("isstring and ispattern high together");

    // Host must stay quiet while a job is running
    quiet_during_job: assert property (@(posedge clk) disable iff (reset)
        (job_start || in_job) |-> !(isstring || ispattern))
        else $error("strobe seen between job start and valid");

endmodule

bind sme_top sme_props u_props
(
    .clk       (clk),
    .reset     (reset),
    .isstring  (isstring),
    .ispattern (ispattern),
    .job_start (job_start),
    .valid     (valid),
    .match     (match)
);

`default_nettype wire

// File: tests/sme_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "sme_settings.svh"

module sme_tb;
    import sme_pkg::*;

    // Worst case scan per job plus load and idle cycles
    localparam int JOB_LIMIT   = 40;
    localparam int CYCLE_LIMIT = JOB_LIMIT * ((`SME_STR_MAX + 1) * `SME_PAT_MAX + 60);

    logic                      clk;
    logic                      reset;
    char_t                     chardata;
    logic                      isstring;
    logic                      ispattern;
    logic                      valid;
    logic                      match;
    logic [`SME_STR_IDX_W-1:0] match_index;

    logic                      exp_match;
    logic [`SME_STR_IDX_W-1:0] exp_index;
    string                     last_str;
    int                        jobs_sent;
    int                        results_seen;
    int                        err_count;
    int                        tests_run;
    int                        cycle_count;
    logic [31:0]               rng_state = 32'h131cfe55;

    sme_top u_dut
    (
        .clk         (clk),
        .reset       (reset),
        .chardata    (chardata),
        .isstring    (isstring),
        .ispattern   (ispattern),
        .valid       (valid),
        .match       (match),
        .match_index (match_index)
    );

    always #5 clk = ~clk;

    // =========================================================================
    // Helpers
    // =========================================================================
    function automatic int rand_below(input int n);
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return int'(rng_state[31:16]) % n;
    endfunction

    function automatic string random_text(input string alphabet, input int len);
        string s;
        int    i;
        s = "";
        for (i = 0; i < len; i++)
            s = $sformatf("%s%c", s, alphabet[rand_below(alphabet.len())]);
        return s;
    endfunction

    // Leftmost start from which every element holds in turn
    function automatic void ref_match(input string s, input string p,
                                      output logic m, output logic [`SME_STR_IDX_W-1:0] idx);
        int   len;
        int   start;
        int   pos;
        int   k;
        logic ok;
        byte  c;
        len = s.len();
        m   = 1'b0;
        idx = '0;
        for (start = 0; start <= len && !m; start++)
        begin
            pos = start;
            ok  = 1'b1;
            for (k = 0; k < p.len() && ok; k++)
            begin
                c = p[k];
                if (c == `SME_CH_DOT)
                    ok = pos < len;
                else if (c == `SME_CH_HAT)
                    ok = (pos == 0) || (s[pos - 1] == `SME_CH_SPACE);
                else if (c == `SME_CH_DOLLAR)
                    ok = (pos == len) || (s[pos] == `SME_CH_SPACE);
                else
                    ok = (pos < len) && (s[pos] == c);
                // Anchors are zero width
                if (ok && c != `SME_CH_HAT && c != `SME_CH_DOLLAR)
                    pos++;
            end
            if (ok)
            begin
                m   = 1'b1;
                idx = start[`SME_STR_IDX_W-1:0];
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %0s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    // Send one job and wait for its result
    task automatic run_job(input string name, input string s, input string p,
                           input bit send_str);
        int i;
        int err_before;
        err_before = err_count;
        if (send_str)
            last_str = s;
        ref_match(last_str, p, exp_match, exp_index);
        if (send_str)
        begin
            for (i = 0; i < s.len(); i++)
            begin
                @(posedge clk);
                isstring  <= 1'b1;
                ispattern <= 1'b0;
                chardata  <= s[i];
            end
        end
        for (i = 0; i < p.len(); i++)
        begin
            @(posedge clk);
            isstring  <= 1'b0;
            ispattern <= 1'b1;
            chardata  <= p[i];
        end
        @(posedge clk);
        isstring  <= 1'b0;
        ispattern <= 1'b0;
        chardata  <= '0;
        jobs_sent++;
        while (results_seen != jobs_sent)
            @(posedge clk);
        tests_run++;
        if (err_count == err_before)
            $display("test %0s: ok", name);
        else
            $display("test %0s: failed", name);
    endtask

    // =========================================================================
    // Result comparison
    // =========================================================================
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (valid && results_seen != jobs_sent)
            begin
                check_value("match", 32'(match), 32'(exp_match));
                if (exp_match)
                    check_value("match_index", 32'(match_index), 32'(exp_index));
                results_seen++;
            end
            else if (valid || match)
            begin
                $display("valid or match raised while no job was pending");
                err_count++;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, a job never returned valid", cycle_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    // =========================================================================
    // Stimulus
    // =========================================================================
    initial
    begin
        string long_str;
        int    n;
        clk          = 1'b0;
        reset        = 1'b1;
        chardata     = '0;
        isstring     = 1'b0;
        ispattern    = 1'b0;
        jobs_sent    = 0;
        results_seen = 0;
        err_count    = 0;
        tests_run    = 0;
        cycle_count  = 0;
        last_str     = "";
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);

        run_job("literal first occurrence", "xxabab", "ab", 1);
        run_job("absent pattern", "abcabc", "xyz", 1);
        long_str = "";
        for (n = 0; n < `SME_STR_MAX; n++)
            long_str = $sformatf("%sa", long_str);
        run_job("long search", long_str, "aaaaaaab", 1);
        run_job("dot inside word", "zzabc", "a.c", 1);
        run_job("dot on space", "a c", "a.c", 1);
        run_job("hat after space", "a cat", "^cat", 1);
        run_job("dollar before space", "dog x", "dog$", 1);
        run_job("empty word", "x  y", "^$", 1);
        // Stored string "x  y" is searched again
        run_job("pattern only", "", "y$", 0);

        for (n = 0; n < 20; n++)
            run_job($sformatf("random %0d", n),
                    random_text("ab ", 1 + rand_below(20)),
                    random_text("ab.^$", 1 + rand_below(4)), 1);

        // Catch any stray pulse after the last job
        repeat (8) @(posedge clk);
        $display("%0d tests run, %0d errors", tests_run, err_count);
        if (err_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+design
design/sme_pkg.sv
design/sme_char_store.sv
design/sme_elem_compare.sv
design/sme_search_ctrl.sv
design/sme_top.sv
tests/sme_props.sv
tests/sme_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module sme_tb -Mdir obj_dir -f build.f

output=$(./obj_dir/Vsme_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -qxF '>>> PASS'; then
    exit 0
fi
exit 1
